// ==== frontend_pkg.sv ====
package frontend_pkg;

    ////////////////////
    // Fetch address
    ////////////////////

    localparam logic [31:0] RESET_PC = 32'h1c00_0000;

    ////////////////////
    // Instruction buffer
    ////////////////////

    localparam int BUF_DEPTH = 8;
    localparam int BUF_PTR_W = 3;
    // Stop fetching early, one word can still be on its way back
    localparam int BUF_STALL_LEVEL = BUF_DEPTH - 2;

    ////////////////////
    // Branch history table
    ////////////////////

    localparam int BHT_ENTRIES = 64;
    localparam int BHT_IDX_W = 6;
    // Weakly not-taken
    localparam logic [1:0] CNT_RESET = 2'b01;

    ////////////////////
    // Opcodes, inst[31:26]
    ////////////////////

    localparam logic [5:0] OPC_B = 6'b010100;
    localparam logic [5:0] OPC_BEQ = 6'b010110;
    localparam logic [5:0] OPC_BNE = 6'b010111;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_UNCOND,
        BR_COND
    } branch_kind_t;

endpackage

// ==== pc_reg.sv ====
`timescale 1ns/1ps

module pc_reg (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        icache_stall,
    input  logic        buf_almost_full,
    input  logic        branch_flush,
    input  logic [31:0] branch_actual_addr,
    input  logic        pred_redirect,
    input  logic [31:0] pred_target,
    output logic [31:0] fetch_pc,
    output logic        fetch_req,
    output logic [31:0] ret_pc
);
    import frontend_pkg::*;

    logic accept;
    logic drop_q;
    logic redirect;

    // No new request while the buffer is close to full
    assign fetch_req = !buf_almost_full;
    assign accept = fetch_req && !icache_stall;

    // Stale word right after a flush or redirect must not steer the PC
    assign redirect = pred_redirect && !drop_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_pc <= RESET_PC;
            drop_q <= 1'b0;
        end else begin
            drop_q <= branch_flush || redirect;
            if (branch_flush) begin
                fetch_pc <= branch_actual_addr;
            end else if (redirect) begin
                fetch_pc <= pred_target;
            end else if (accept) begin
                fetch_pc <= fetch_pc + 32'd4;
            end
        end
    end

    // PC of the word the icache returns next cycle
    always_ff @(posedge clk) begin
        if (accept) begin
            ret_pc <= fetch_pc;
        end
    end

    a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_pc[1:0] == 2'b00);

endmodule

// ==== bpu.sv ====
`timescale 1ns/1ps

module bpu (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        icache_valid,
    input  logic [31:0] icache_inst,
    input  logic [31:0] ret_pc,
    input  logic        update_valid,
    input  logic [31:0] update_pc,
    input  logic        update_taken,
    output logic        pred_redirect,
    output logic        pred_taken,
    output logic [31:0] pred_target
);
    import frontend_pkg::*;

    branch_kind_t kind;
    logic [1:0] bht [BHT_ENTRIES];
    logic [BHT_IDX_W-1:0] rd_idx;
    logic [BHT_IDX_W-1:0] wr_idx;
    logic [1:0] wr_cnt;
    logic [31:0] offs_b;
    logic [31:0] offs_cond;

    ////////////////////
    // Predecode
    ////////////////////

    always_comb begin
        case (icache_inst[31:26])
            OPC_B: kind = BR_UNCOND;
            OPC_BEQ,
            OPC_BNE: kind = BR_COND;
            default: kind = BR_NONE;
        endcase
    end

    // B splits offs26, high part in inst[9:0], low part in inst[25:10]
    assign offs_b = {{4{icache_inst[9]}}, icache_inst[9:0], icache_inst[25:10], 2'b00};
    assign offs_cond = {{14{icache_inst[25]}}, icache_inst[25:10], 2'b00};

    ////////////////////
    // Prediction
    ////////////////////

    assign rd_idx = ret_pc[BHT_IDX_W+1:2];

    always_comb begin
        pred_taken = 1'b0;
        pred_target = ret_pc + 32'd4;
        case (kind)
            BR_UNCOND: begin
                pred_taken = 1'b1;
                pred_target = ret_pc + offs_b;
            end
            BR_COND: begin
                // MSB of the counter is the direction
                pred_taken = bht[rd_idx][1];
                pred_target = ret_pc + offs_cond;
            end
            default: begin
                pred_taken = 1'b0;
            end
        endcase
    end

    assign pred_redirect = pred_taken && icache_valid;

    ////////////////////
    // Training
    ////////////////////

    assign wr_idx = update_pc[BHT_IDX_W+1:2];
    assign wr_cnt = bht[wr_idx];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < BHT_ENTRIES; i++) begin
                bht[i] <= CNT_RESET;
            end
        end else if (update_valid) begin
            // Saturate at strongly taken / strongly not-taken
            if (update_taken && wr_cnt != 2'b11) begin
                bht[wr_idx] <= wr_cnt + 2'd1;
            end else if (!update_taken && wr_cnt != 2'b00) begin
                bht[wr_idx] <= wr_cnt - 2'd1;
            end
        end
    end

endmodule

// ==== instbuffer.sv ====
`timescale 1ns/1ps

module instbuffer (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        branch_flush,
    input  logic        pred_redirect,
    input  logic        icache_valid,
    input  logic [31:0] ret_pc,
    input  logic [31:0] icache_inst,
    input  logic        pred_taken,
    input  logic [31:0] pred_target,
    input  logic        send_inst_en,
    output logic        out_valid,
    output logic [31:0] out_pc,
    output logic [31:0] out_inst,
    output logic        out_pred_taken,
    output logic [31:0] out_pred_target,
    output logic        buf_almost_full
);
    import frontend_pkg::*;

    logic [31:0] pc_mem [BUF_DEPTH];
    logic [31:0] inst_mem [BUF_DEPTH];
    logic taken_mem [BUF_DEPTH];
    logic [31:0] target_mem [BUF_DEPTH];

    logic [BUF_PTR_W-1:0] wr_ptr;
    logic [BUF_PTR_W-1:0] rd_ptr;
    logic [BUF_PTR_W:0] count;
    logic squash_q;
    logic push;
    logic pop;

    // The return one cycle after a redirect or flush is wrong-path
    assign push = icache_valid && !squash_q && !branch_flush;
    assign pop = out_valid && send_inst_en && !branch_flush;

    assign out_valid = count != '0;
    assign buf_almost_full = count >= (BUF_PTR_W + 1)'(BUF_STALL_LEVEL);

    // Head of queue
    assign out_pc = pc_mem[rd_ptr];
    assign out_inst = inst_mem[rd_ptr];
    assign out_pred_taken = taken_mem[rd_ptr];
    assign out_pred_target = target_mem[rd_ptr];

    ////////////////////
    // Pointers
    ////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            squash_q <= 1'b0;
        end else begin
            // A squashed word never raises pred_redirect for itself
            squash_q <= branch_flush || (pred_redirect && !squash_q);
            if (branch_flush) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
                count <= '0;
            end else begin
                if (push) begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
                if (pop) begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
                case ({push, pop})
                    2'b10: count <= count + 1'b1;
                    2'b01: count <= count - 1'b1;
                    default: count <= count;
                endcase
            end
        end
    end

    ////////////////////
    // Storage
    ////////////////////

    always_ff @(posedge clk) begin
        if (push) begin
            pc_mem[wr_ptr] <= ret_pc;
            inst_mem[wr_ptr] <= icache_inst;
            taken_mem[wr_ptr] <= pred_taken;
            target_mem[wr_ptr] <= pred_target;
        end
    end

    // Fetch back-pressure must leave room for the word in flight
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        push |-> count != (BUF_PTR_W + 1)'(BUF_DEPTH));

endmodule

// ==== frontend_top.sv ====
`timescale 1ns/1ps

module frontend_top (
    input  logic        clk,
    input  logic        rst_n,

    // icache
    output logic [31:0] icache_pc,
    output logic        icache_req,
    input  logic        icache_stall,
    input  logic        icache_valid,
    input  logic [31:0] icache_inst,

    // Backend
    input  logic        branch_flush,
    input  logic [31:0] branch_actual_addr,
    input  logic        update_valid,
    input  logic [31:0] update_pc,
    input  logic        update_taken,
    input  logic        send_inst_en,
    output logic        out_valid,
    output logic [31:0] out_pc,
    output logic [31:0] out_inst,
    output logic        out_pred_taken,
    output logic [31:0] out_pred_target
);

    logic [31:0] ret_pc;
    logic pred_redirect;
    logic pred_taken;
    logic [31:0] pred_target;
    logic buf_almost_full;

    pc_reg u_pc_reg (
        .clk,
        .rst_n,
        .icache_stall,
        .buf_almost_full,
        .branch_flush,
        .branch_actual_addr,
        .pred_redirect,
        .pred_target,
        .fetch_pc(icache_pc),
        .fetch_req(icache_req),
        .ret_pc
    );

    bpu u_bpu (
        .clk,
        .rst_n,
        .icache_valid,
        .icache_inst,
        .ret_pc,
        .update_valid,
        .update_pc,
        .update_taken,
        .pred_redirect,
        .pred_taken,
        .pred_target
    );

    instbuffer u_instbuffer (
        .clk,
        .rst_n,
        .branch_flush,
        .pred_redirect,
        .icache_valid,
        .ret_pc,
        .icache_inst,
        .pred_taken,
        .pred_target,
        .send_inst_en,
        .out_valid,
        .out_pc,
        .out_inst,
        .out_pred_taken,
        .out_pred_target,
        .buf_almost_full
    );

endmodule

// ==== tb_frontend.sv ====
`timescale 1ns/1ps

module tb_frontend;
    import frontend_pkg::*;

    localparam int TIMEOUT = 200;
    localparam int NUM_PHASES = 6;
    localparam int MEM_WORDS = 128;

    typedef struct {
        bit           flush;
        logic [31:0]  start_pc;
        logic [31:0]  br_pc;
        branch_kind_t br_kind;
        int           br_offs;
        int           n_upd;
        int           n_pops;
        int           mode;
    } phase_t;

    logic clk;
    logic rst_n;
    logic [31:0] icache_pc;
    logic icache_req;
    logic icache_stall;
    logic icache_valid;
    logic [31:0] icache_inst;
    logic branch_flush;
    logic [31:0] branch_actual_addr;
    logic update_valid;
    logic [31:0] update_pc;
    logic update_taken;
    logic send_inst_en;
    logic out_valid;
    logic [31:0] out_pc;
    logic [31:0] out_inst;
    logic out_pred_taken;
    logic [31:0] out_pred_target;

    // Program image at RESET_PC with fill elsewhere
    logic [31:0] mem_word [MEM_WORDS];
    branch_kind_t mem_kind [MEM_WORDS];
    logic [31:0] mem_tgt [MEM_WORDS];
    logic [1:0] cnt [BHT_ENTRIES];
    bit stall_rand;

    // flush, start, branch slot, kind, word offset, taken updates, pops, mode
    // mode 0 steady pops, 1 fill then drain, 2 random stalls and gaps
    phase_t phases [NUM_PHASES] = '{
        '{1'b0, RESET_PC, 32'd0, BR_NONE, 0, 0, 6, 0},
        '{1'b1, RESET_PC + 32'h38, RESET_PC + 32'h40, BR_UNCOND, 8, 0, 6, 0},
        '{1'b1, RESET_PC + 32'h78, RESET_PC + 32'h80, BR_COND, 16, 0, 5, 0},
        '{1'b1, RESET_PC + 32'h7c, RESET_PC + 32'h80, BR_COND, 16, 2, 4, 0},
        '{1'b1, RESET_PC + 32'h100, 32'd0, BR_NONE, 0, 0, BUF_DEPTH + 2, 1},
        '{1'b1, RESET_PC + 32'h30, 32'd0, BR_NONE, 0, 0, 20, 2}
    };

    frontend_top frontend_top_inst (.*);

    always #50 clk = ~clk;

    ////////////////////
    // Memory model
    ////////////////////

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return {6'b000001, addr[27:2] ^ {20'd0, addr[31:26]}};
    endfunction

    function automatic int region_idx(input logic [31:0] addr);
        logic [31:0] off;
        off = addr - RESET_PC;
        return (off < 32'h200) ? int'(off[8:2]) : -1;
    endfunction

    function automatic logic [31:0] read_word(input logic [31:0] addr);
        int i;
        i = region_idx(addr);
        return (i >= 0) ? mem_word[i] : fill_word(addr);
    endfunction

    // One-cycle icache that accepts nothing while stalled
    always @(posedge clk) begin
        icache_valid <= icache_req && !icache_stall && rst_n;
        icache_inst <= read_word(icache_pc);
        icache_stall <= stall_rand ? ($urandom_range(3) == 0) : 1'b0;
    end

    ////////////////////
    // Checks
    ////////////////////

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
            $display("TB FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out after %0d cycles waiting for %s", TIMEOUT, what);
        $display("TB FAILED");
        $fatal(1, "timeout");
    endtask

    // Reference prediction from the image and the counter mirror
    function automatic void predict(input logic [31:0] pc, output logic taken,
                                    output logic [31:0] tgt);
        int i;
        i = region_idx(pc);
        taken = 1'b0;
        tgt = 32'd0;
        if (i >= 0) begin
            tgt = mem_tgt[i];
            taken = (mem_kind[i] == BR_UNCOND) || (mem_kind[i] == BR_COND && cnt[pc[7:2]][1]);
        end
    endfunction

    ////////////////////
    // Stimulus
    ////////////////////

    task automatic train(input logic [31:0] pc, input logic taken);
        @(posedge clk);
        update_valid <= 1'b1;
        update_pc <= pc;
        update_taken <= taken;
        @(posedge clk);
        update_valid <= 1'b0;
        if (taken && cnt[pc[7:2]] != 2'b11) begin
            cnt[pc[7:2]] = cnt[pc[7:2]] + 2'd1;
        end else if (!taken && cnt[pc[7:2]] != 2'b00) begin
            cnt[pc[7:2]] = cnt[pc[7:2]] - 2'd1;
        end
    endtask

    task automatic flush_to(input logic [31:0] addr);
        @(posedge clk);
        branch_flush <= 1'b1;
        branch_actual_addr <= addr;
        @(posedge clk);
        branch_flush <= 1'b0;
    endtask

    task automatic setup_phase(input phase_t p);
        int idx;
        logic [25:0] o;
        // Image changes between edges and the flush drops anything stale
        @(negedge clk);
        stall_rand = (p.mode == 2);
        if (p.br_pc != 32'd0) begin
            idx = region_idx(p.br_pc);
            o = 26'(p.br_offs);
            mem_kind[idx] = p.br_kind;
            mem_tgt[idx] = p.br_pc + 32'(p.br_offs * 4);
            if (p.br_kind == BR_UNCOND) begin
                mem_word[idx] = {OPC_B, o[15:0], o[25:16]};
            end else begin
                mem_word[idx] = {OPC_BEQ, o[15:0], 10'd0};
            end
        end
        repeat (p.n_upd) train(p.br_pc, 1'b1);
        if (p.flush) begin
            flush_to(p.start_pc);
        end
    endtask

    // Backend held off until fetch stops on a nearly full buffer
    task automatic wait_full(input logic [31:0] start);
        int t;
        t = 0;
        do begin
            @(posedge clk);
            t++;
            if (t > TIMEOUT) begin
                report_timeout("the buffer to fill");
            end
        end while (icache_req);
        // Fetch parks on the word after the one still in flight
        repeat (4) begin
            @(posedge clk);
            check("icache_req", 32'(icache_req), 32'd0);
            check("icache_pc", icache_pc, start + 32'(4 * (BUF_STALL_LEVEL + 1)));
        end
    endtask

    task automatic drain(input logic [31:0] start, input int n, input bit gaps);
        logic [31:0] pc;
        logic taken;
        logic [31:0] tgt;
        int got;
        int idle;
        pc = start;
        got = 0;
        idle = 0;
        @(posedge clk);
        send_inst_en <= 1'b1;
        while (got < n) begin
            @(posedge clk);
            if (out_valid && send_inst_en) begin
                predict(pc, taken, tgt);
                check("out_pc", out_pc, pc);
                check("out_inst", out_inst, read_word(pc));
                check("out_pred_taken", 32'(out_pred_taken), 32'(taken));
                if (taken) begin
                    check("out_pred_target", out_pred_target, tgt);
                end
                pc = taken ? tgt : pc + 32'd4;
                got++;
                idle = 0;
            end else begin
                idle++;
                if (idle > TIMEOUT) begin
                    report_timeout("an instruction to pop");
                end
            end
            send_inst_en <= (got < n) && (!gaps || $urandom_range(3) != 0);
        end
    endtask

    initial begin
        void'($urandom(87));
        clk = 1'b0;
        rst_n = 1'b0;
        icache_stall = 1'b0;
        icache_valid = 1'b0;
        icache_inst = 32'd0;
        branch_flush = 1'b0;
        branch_actual_addr = 32'd0;
        update_valid = 1'b0;
        update_pc = 32'd0;
        update_taken = 1'b0;
        send_inst_en = 1'b0;
        stall_rand = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem_word[i] = fill_word(RESET_PC + 32'(i * 4));
            mem_kind[i] = BR_NONE;
            mem_tgt[i] = 32'd0;
        end
        for (int j = 0; j < BHT_ENTRIES; j++) begin
            cnt[j] = CNT_RESET;
        end
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        for (int k = 0; k < NUM_PHASES; k++) begin
            setup_phase(phases[k]);
            if (phases[k].mode == 1) begin
                wait_full(phases[k].start_pc);
            end
            drain(phases[k].start_pc, phases[k].n_pops, phases[k].mode == 2);
        end
        $display("TB PASSED");
        $finish;
    end

endmodule

// ==== vlog.f ====
frontend_pkg.sv
pc_reg.sv
bpu.sv
instbuffer.sv
frontend_top.sv
tb_frontend.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_frontend
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal

.PHONY: sim clean

# Build and run, pass only when the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)
